/* rtl/spiPkg.sv */
// SPI controller shared definitions
package spiPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Register map, byte addresses on the APB side
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [7:0] SckDivAddr  = 8'h00;    // SCLK divider
    localparam logic [7:0] SckModeAddr = 8'h04;    // Polarity in bit 1, phase in bit 0
    localparam logic [7:0] CsIdAddr    = 8'h10;
    localparam logic [7:0] CsDefAddr   = 8'h14;
    localparam logic [7:0] CsModeAddr  = 8'h18;
    localparam logic [7:0] TxDataAddr  = 8'h48;    // Push side of transmit FIFO
    localparam logic [7:0] RxDataAddr  = 8'h4C;    // Pop side of receive FIFO
    localparam logic [7:0] TxMarkAddr  = 8'h50;
    localparam logic [7:0] RxMarkAddr  = 8'h54;
    localparam logic [7:0] IeAddr      = 8'h70;
    localparam logic [7:0] IpAddr      = 8'h74;    // Read only

    // Field widths
    localparam int DataWidth   = 32;               // APB data bus
    localparam int SckDivWidth = 12;
    localparam int FrameBits   = 8;                // Fixed frame length, MSB first
    localparam int CsWidth     = 4;                // Chip select pins
    localparam int FifoDepth   = 8;
    localparam int CountWidth  = 4;                // Occupancy 0 to FifoDepth
    localparam int MarkWidth   = 3;

    // Reset values of the registers that do not clear to zero
    localparam logic [SckDivWidth-1:0] SckDivReset = 12'd3;
    localparam logic [CsWidth-1:0]     CsDefReset  = 4'b1111;

    localparam logic [1:0] CsModeOff = 2'd3;       // Other codes run chip select in auto mode

    // Flag positions in the data register reads
    localparam int TxFullBit  = 31;
    localparam int RxEmptyBit = 31;

    // Frame engine states
    typedef enum logic [1:0] {Idle, Lead, Shift, Trail} engineState;

endpackage

/* rtl/spiFifo.sv */
// SPI byte FIFO
`timescale 1ns/10ps

module spiFifo import spiPkg::*; (
    input  logic                  PCLK,
    input  logic                  PRESETn,
    input  logic                  push,
    input  logic [FrameBits-1:0]  pushData,
    input  logic                  pop,
    output logic [FrameBits-1:0]  popData,
    output logic                  full,
    output logic                  empty,
    output logic [CountWidth-1:0] count
);

    logic [FrameBits-1:0]  mem [FifoDepth];       // Storage
    logic [CountWidth-2:0] wrPtr;                 // Wraps at FifoDepth
    logic [CountWidth-2:0] rdPtr;
    logic                  doPush;
    logic                  doPop;

    assign full    = (count == CountWidth'(FifoDepth));
    assign empty   = (count == '0);
    assign doPush  = push & ~full;                // Push into a full FIFO is lost
    assign doPop   = pop & ~empty;
    assign popData = mem[rdPtr];                  // Head visible without a pop

    always_ff @(posedge PCLK) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= wrPtr + 1'b1;
            if (doPop) rdPtr <= rdPtr + 1'b1;
            count <= count + CountWidth'(doPush) - CountWidth'(doPop);
        end
    end

endmodule

/* rtl/spiRegs.sv */
// SPI APB register block
`timescale 1ns/10ps

module spiRegs import spiPkg::*; (
    input  logic                   PCLK,
    input  logic                   PRESETn,
    input  logic                   PSEL,
    input  logic                   PENABLE,
    input  logic                   PWRITE,
    input  logic [7:0]             PADDR,
    input  logic [DataWidth-1:0]   PWDATA,
    input  logic                   idle,      // Engine has no frame in flight
    input  logic                   txFull,
    input  logic                   rxEmpty,
    input  logic [CountWidth-1:0]  txCount,
    input  logic [CountWidth-1:0]  rxCount,
    input  logic [FrameBits-1:0]   rxHead,
    output logic [DataWidth-1:0]   PRDATA,
    output logic                   PREADY,
    output logic                   txPush,
    output logic [FrameBits-1:0]   txData,
    output logic                   rxPop,
    output logic [SckDivWidth-1:0] sckDiv,
    output logic [1:0]             sckMode,
    output logic [1:0]             csId,
    output logic [CsWidth-1:0]     csDef,
    output logic [1:0]             csMode,
    output logic [MarkWidth-1:0]   txMark,
    output logic [MarkWidth-1:0]   rxMark,
    output logic                   SPIIntr
);

    logic [7:0] regAddr;                          // Word aligned offset
    logic       wrDone;                           // Write completes this cycle
    logic       rdDone;                           // Read completes this cycle
    logic [1:0] ie;                               // Interrupt enable
    logic [1:0] ip;                               // Interrupt pending

    assign regAddr = {PADDR[7:2], 2'b00};
    assign PREADY  = idle;                        // Hold the bus while a frame is on the wire
    assign wrDone  = PSEL & PENABLE & PWRITE & PREADY;
    assign rdDone  = PSEL & PENABLE & ~PWRITE & PREADY;

    ////////////////////////////////////////////////////////////////////////////
    // Control register writes
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            sckDiv  <= SckDivReset;
            sckMode <= '0;
            csId    <= '0;
            csDef   <= CsDefReset;
            csMode  <= '0;
            txMark  <= '0;
            rxMark  <= '0;
            ie      <= '0;
        end else if (wrDone) begin
            case (regAddr)
                SckDivAddr:  sckDiv  <= PWDATA[SckDivWidth-1:0];
                SckModeAddr: sckMode <= PWDATA[1:0];
                CsIdAddr:    csId    <= PWDATA[1:0];
                CsDefAddr:   csDef   <= PWDATA[CsWidth-1:0];
                CsModeAddr:  csMode  <= PWDATA[1:0];
                TxMarkAddr:  txMark  <= PWDATA[MarkWidth-1:0];
                RxMarkAddr:  rxMark  <= PWDATA[MarkWidth-1:0];
                IeAddr:      ie      <= PWDATA[1:0];
                default: ;                        // TXDATA handled below, IP is read only
            endcase
        end
    end

    // FIFO strobes, one cycle after the APB transfer completes
    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            txPush <= 1'b0;
            rxPop  <= 1'b0;
        end else begin
            txPush <= wrDone & (regAddr == TxDataAddr) & ~txFull;   // Dropped when full
            rxPop  <= rdDone & (regAddr == RxDataAddr) & ~rxEmpty;
        end
    end

    // Byte that travels with txPush
    always_ff @(posedge PCLK) begin
        if (wrDone && regAddr == TxDataAddr) begin
            txData <= PWDATA[FrameBits-1:0];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Interrupts
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            ip <= '0;
        end else begin
            ip[0] <= (txCount < {1'b0, txMark});  // Transmit below mark
            ip[1] <= (rxCount > {1'b0, rxMark});  // Receive above mark
        end
    end

    assign SPIIntr = |(ip & ie);

    // Read mux, sampled every cycle so data is stable during the access phase
    always_ff @(posedge PCLK) begin
        PRDATA <= '0;                             // Unmapped offsets read zero
        case (regAddr)
            SckDivAddr:  PRDATA[SckDivWidth-1:0] <= sckDiv;
            SckModeAddr: PRDATA[1:0] <= sckMode;
            CsIdAddr:    PRDATA[1:0] <= csId;
            CsDefAddr:   PRDATA[CsWidth-1:0] <= csDef;
            CsModeAddr:  PRDATA[1:0] <= csMode;
            TxDataAddr:  PRDATA[TxFullBit] <= txFull;
            RxDataAddr: begin
                PRDATA[RxEmptyBit]    <= rxEmpty;
                PRDATA[FrameBits-1:0] <= rxHead;  // Head byte, valid when not empty
            end
            TxMarkAddr:  PRDATA[MarkWidth-1:0] <= txMark;
            RxMarkAddr:  PRDATA[MarkWidth-1:0] <= rxMark;
            IeAddr:      PRDATA[1:0] <= ie;
            IpAddr:      PRDATA[1:0] <= ip;
            default: ;
        endcase
    end

endmodule

/* rtl/spiEngine.sv */
// SPI frame engine
`timescale 1ns/10ps

module spiEngine import spiPkg::*; (
    input  logic                   PCLK,
    input  logic                   PRESETn,
    input  logic [SckDivWidth-1:0] sckDiv,
    input  logic [1:0]             sckMode,   // [1] polarity, [0] phase
    input  logic [1:0]             csId,
    input  logic [CsWidth-1:0]     csDef,
    input  logic [1:0]             csMode,
    input  logic                   txEmpty,
    input  logic [FrameBits-1:0]   txHead,
    input  logic                   SPIIn,
    output logic                   txPop,
    output logic                   rxPush,
    output logic [FrameBits-1:0]   rxByte,
    output logic                   idle,
    output logic                   SCLK,
    output logic                   SPIOut,
    output logic [CsWidth-1:0]     SPICS
);

    logic [SckDivWidth-1:0]          divCount;
    logic                            tick;        // One PCLK cycle per SCLK half period
    engineState                      state;
    logic [$clog2(2*FrameBits)-1:0]  edgeCount;   // SCLK edge within the frame, from 0
    logic                            sclkToggle;  // SCLK away from idle polarity
    logic [FrameBits-1:0]            txShift;
    logic [FrameBits-1:0]            rxShift;
    logic                            shiftTick;
    logic                            sampleEdge;
    logic                            shiftEdge;
    logic [CsWidth-1:0]              csSelect;

    ////////////////////////////////////////////////////////////////////////////
    // Clock divider, free running
    ////////////////////////////////////////////////////////////////////////////
    assign tick = (divCount >= sckDiv);           // Also recovers if sckDiv shrinks

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            divCount <= '0;
        end else if (tick) begin
            divCount <= '0;
        end else begin
            divCount <= divCount + 1'b1;
        end
    end

    // Frame FSM, steps only on a tick
    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            state      <= Idle;
            edgeCount  <= '0;
            sclkToggle <= 1'b0;
        end else if (tick) begin
            case (state)
                Idle: begin
                    if (!txEmpty) state <= Lead;  // Byte latched with txPop
                end
                Lead: begin
                    state     <= Shift;
                    edgeCount <= '0;
                end
                Shift: begin
                    sclkToggle <= ~sclkToggle;
                    edgeCount  <= edgeCount + 1'b1;
                    if (edgeCount == '1) state <= Trail;   // Sixteenth edge
                end
                Trail: begin
                    state <= Idle;
                end
                default: state <= Idle;
            endcase
        end
    end

    assign idle   = (state == Idle);
    assign txPop  = tick & idle & ~txEmpty;
    assign rxPush = tick & (state == Trail);      // End of frame
    assign rxByte = rxShift;
    assign SCLK   = sckMode[1] ^ sclkToggle;      // Idle polarity outside Shift

    ////////////////////////////////////////////////////////////////////////////
    // Shift registers
    ////////////////////////////////////////////////////////////////////////////
    // Phase 0 samples odd edges, phase 1 samples even edges
    assign shiftTick  = tick & (state == Shift);
    assign sampleEdge = shiftTick & (edgeCount[0] == sckMode[0]);
    // First edge in phase 1 launches the MSB already on the line
    assign shiftEdge  = shiftTick & (edgeCount[0] != sckMode[0]) & (edgeCount != '0);

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            txShift <= '0;
        end else if (txPop) begin
            txShift <= txHead;
        end else if (shiftEdge) begin
            txShift <= {txShift[FrameBits-2:0], 1'b0};
        end
    end

    assign SPIOut = txShift[FrameBits-1];         // MSB first

    always_ff @(posedge PCLK) begin
        if (sampleEdge) begin
            rxShift <= {rxShift[FrameBits-2:0], SPIIn};
        end
    end

    // Chip select, selected pin inverted from its default during a frame
    assign csSelect = CsWidth'(1) << csId;
    assign SPICS    = (idle || csMode == CsModeOff) ? csDef : (csDef ^ csSelect);

endmodule

/* rtl/spiApb.sv */
// SPI controller top level
`timescale 1ns/10ps

module spiApb import spiPkg::*; (
    input  logic                 PCLK,
    input  logic                 PRESETn,
    input  logic                 PSEL,
    input  logic                 PENABLE,
    input  logic                 PWRITE,
    input  logic [7:0]           PADDR,
    input  logic [DataWidth-1:0] PWDATA,
    input  logic                 SPIIn,
    output logic [DataWidth-1:0] PRDATA,
    output logic                 PREADY,
    output logic                 SCLK,
    output logic                 SPIOut,
    output logic [CsWidth-1:0]   SPICS,
    output logic                 SPIIntr
);

    // Register block to FIFOs
    logic                   txPush;
    logic [FrameBits-1:0]   txData;
    logic                   rxPop;
    logic                   txFull;
    logic                   rxEmpty;
    logic [CountWidth-1:0]  txCount;
    logic [CountWidth-1:0]  rxCount;
    logic [FrameBits-1:0]   rxHead;

    // Register block to engine
    logic [SckDivWidth-1:0] sckDiv;
    logic [1:0]             sckMode;
    logic [1:0]             csId;
    logic [CsWidth-1:0]     csDef;
    logic [1:0]             csMode;
    logic                   idle;

    // FIFOs to engine
    logic                   txPop;
    logic                   txEmpty;
    logic [FrameBits-1:0]   txHead;
    logic                   rxPush;
    logic [FrameBits-1:0]   rxByte;

    // Watermarks stay inside the register block
    spiRegs regs (
        .PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
        .idle, .txFull, .rxEmpty, .txCount, .rxCount, .rxHead,
        .PRDATA, .PREADY, .txPush, .txData, .rxPop,
        .sckDiv, .sckMode, .csId, .csDef, .csMode, .txMark(), .rxMark(), .SPIIntr
    );

    spiFifo txFifo (
        .PCLK, .PRESETn,
        .push(txPush), .pushData(txData), .pop(txPop),
        .popData(txHead), .full(txFull), .empty(txEmpty), .count(txCount)
    );

    // Receive side, a push into a full FIFO loses the byte
    spiFifo rxFifo (
        .PCLK, .PRESETn,
        .push(rxPush), .pushData(rxByte), .pop(rxPop),
        .popData(rxHead), .full(), .empty(rxEmpty), .count(rxCount)
    );

    spiEngine engine (
        .PCLK, .PRESETn, .sckDiv, .sckMode, .csId, .csDef, .csMode,
        .txEmpty, .txHead, .SPIIn,
        .txPop, .rxPush, .rxByte, .idle, .SCLK, .SPIOut, .SPICS
    );

endmodule

/* verification/spiApb_checker.sv */
// SPI pin protocol assertions
`timescale 1ns/10ps

module spiApbChecker import spiPkg::*; (
    input logic               PCLK,
    input logic               PRESETn,
    input logic               idle,
    input logic               SCLK,
    input logic [1:0]         sckMode,
    input logic [CsWidth-1:0] SPICS,
    input logic [CsWidth-1:0] csDef,
    input logic               rxPush
);

    int failCount;                                // Assertion failures seen

    ////////////////////////////////////////////////////////////////////////////
    // SCLK and chip select relation
    ////////////////////////////////////////////////////////////////////////////
    idleClock: assert property (@(posedge PCLK) disable iff (!PRESETn)
        idle |-> (SCLK == sckMode[1]))
        else begin
            $error("SCLK away from its polarity while the engine is idle");
            failCount++;
        end

    // Select edges only with SCLK at rest
    csEdge: assert property (@(posedge PCLK) disable iff (!PRESETn)
        $changed(SPICS) |-> (SCLK == sckMode[1]))
        else begin
            $error("SPICS changed while SCLK was active");
            failCount++;
        end

    csOneHot: assert property (@(posedge PCLK) disable iff (!PRESETn)
        $onehot0(SPICS ^ csDef))
        else begin
            $error("More than one SPICS pin differs from its default");
            failCount++;
        end

    // One push per frame end
    pushPulse: assert property (@(posedge PCLK) disable iff (!PRESETn)
        rxPush |=> !rxPush)
        else begin
            $error("rxPush held high for two cycles");
            failCount++;
        end

endmodule

bind spiEngine spiApbChecker protoCheck (
    .PCLK(PCLK), .PRESETn(PRESETn), .idle(idle), .SCLK(SCLK), .sckMode(sckMode),
    .SPICS(SPICS), .csDef(csDef), .rxPush(rxPush)
);

/* verification/spiApbTb.sv */
// SPI controller testbench
`timescale 1ns/10ps

module spiApbTb import spiPkg::*; ();

    localparam int ClockPeriod  = 100;            // ns
    localparam int TotalFrames  = 31;             // Frames sent over all tests
    localparam int FrameHalves  = 20;             // Half periods per frame, with slack
    localparam int DivCycles    = 2;              // SCKDIV 1 while frames run
    localparam int MarginCycles = 3000;           // Reset and APB traffic
    localparam int TimeoutNs =
        (TotalFrames * FrameHalves * DivCycles + MarginCycles) * ClockPeriod;

    logic                 PCLK    = 1'b0;
    logic                 PRESETn = 1'b0;
    logic                 PSEL    = 1'b0;
    logic                 PENABLE = 1'b0;
    logic                 PWRITE  = 1'b0;
    logic [7:0]           PADDR   = '0;
    logic [DataWidth-1:0] PWDATA  = '0;
    logic [DataWidth-1:0] PRDATA;
    logic                 PREADY;
    logic                 SCLK;
    logic                 spiLine;                // SPIOut looped back into SPIIn
    logic [CsWidth-1:0]   SPICS;
    logic                 SPIIntr;

    int         seed = 17;
    int         errors;
    int         testsPassed;
    int         testsFailed;
    int         sclkEdges;                        // SCLK transitions seen so far
    logic [7:0] sent [$];                         // Bytes still due back on RXDATA

    // Register reset table
    logic [7:0]           resetAddr  [10] = '{SckDivAddr, SckModeAddr, CsIdAddr, CsDefAddr,
        CsModeAddr, TxDataAddr, TxMarkAddr, RxMarkAddr, IeAddr, IpAddr};
    logic [DataWidth-1:0] resetValue [10] = '{32'd3, 32'd0, 32'd0, 32'hF, 32'd0, 32'd0,
        32'd0, 32'd0, 32'd0, 32'd0};

    spiApb DUT (
        .PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
        .SPIIn(spiLine), .PRDATA, .PREADY, .SCLK, .SPIOut(spiLine), .SPICS, .SPIIntr
    );

    always #(ClockPeriod / 2) PCLK = ~PCLK;
    always @(SCLK) sclkEdges++;                   // 16 per frame

    initial begin
        #(TimeoutNs);
        $display("Watchdog expired before the SPI frames completed");
        $display("CHECKS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // APB access and check helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic writeReg(input logic [7:0] addr, input logic [DataWidth-1:0] data);
        @(posedge PCLK);
        PSEL    <= 1'b1;                          // Setup phase
        PWRITE  <= 1'b1;
        PADDR   <= addr;
        PWDATA  <= data;
        @(posedge PCLK);
        PENABLE <= 1'b1;                          // Access phase
        do @(posedge PCLK); while (!PREADY);      // Stalled while a frame runs
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
        @(posedge PCLK);                          // Strobes and IP settle
    endtask

    task automatic readReg(input logic [7:0] addr, output logic [DataWidth-1:0] data);
        @(posedge PCLK);
        PSEL    <= 1'b1;
        PWRITE  <= 1'b0;
        PADDR   <= addr;
        @(posedge PCLK);
        PENABLE <= 1'b1;
        do @(posedge PCLK); while (!PREADY);
        data = PRDATA;                            // Value at the completing edge
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
        @(posedge PCLK);
    endtask

    task automatic compareValue(input string name, input logic [DataWidth-1:0] expected,
                                input logic [DataWidth-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic reportTest(input string name, input int startErrors);
        if (errors == startErrors) begin
            $display("PASS %s", name);
            testsPassed++;
        end else begin
            $display("FAIL %s with %0d mismatches", name, errors - startErrors);
            testsFailed++;
        end
    endtask

    // Push random bytes, then wait until the last frame has left Trail
    task automatic sendBytes(input int count);
        int         target;
        logic [7:0] data;
        target = sclkEdges + 16 * count;
        for (int i = 0; i < count; i++) begin
            data = 8'($random(seed));
            sent.push_back(data);
            writeReg(TxDataAddr, {24'h0, data});
        end
        wait (sclkEdges >= target);
        do @(posedge PCLK); while (!PREADY);      // Byte now in RX FIFO
    endtask

    task automatic readRx(input string name);
        logic [DataWidth-1:0] data;
        logic [7:0]           expected;
        expected = sent.pop_front();
        readReg(RxDataAddr, data);
        compareValue(name, {24'h0, expected}, data);   // Empty flag clear
    endtask

    // Chip select checked on every cycle of the frame
    task automatic watchFrame(input string name, input logic [CsWidth-1:0] csExpected);
        do @(posedge PCLK); while (PREADY);
        while (!PREADY) begin
            compareValue(name, {28'h0, csExpected}, {28'h0, SPICS});
            @(posedge PCLK);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        logic [DataWidth-1:0] data;
        int                   mark;

        repeat (10) @(posedge PCLK);
        PRESETn <= 1'b1;

        mark = errors;
        for (int i = 0; i < 10; i++) begin
            readReg(resetAddr[i], data);
            compareValue($sformatf("reset %h", resetAddr[i]), resetValue[i], data);
        end
        readReg(RxDataAddr, data);
        compareValue("reset rx empty", 32'd1, {31'h0, data[RxEmptyBit]});
        compareValue("reset chip select", 32'hF, {28'h0, SPICS});
        compareValue("reset interrupt", 32'd0, {31'h0, SPIIntr});
        reportTest("reset values", mark);

        mark = errors;
        writeReg(SckDivAddr, 32'd1);
        for (int mode = 0; mode < 4; mode++) begin
            writeReg(SckModeAddr, 32'(mode));
            sendBytes(4);
            repeat (4) readRx($sformatf("loopback mode %0d", mode));
        end
        reportTest("loopback all modes", mark);

        mark = errors;
        writeReg(CsIdAddr, 32'd2);
        writeReg(CsDefAddr, 32'hF);
        writeReg(TxDataAddr, 32'hA5);
        watchFrame("cs auto", 4'b1011);           // Pin 2 pulled low
        readReg(RxDataAddr, data);
        compareValue("cs auto loopback", 32'hA5, data);
        writeReg(CsModeAddr, {30'h0, CsModeOff});
        writeReg(TxDataAddr, 32'h3C);
        watchFrame("cs off", 4'b1111);
        readReg(RxDataAddr, data);
        compareValue("cs off loopback", 32'h3C, data);
        reportTest("chip select modes", mark);

        mark = errors;
        writeReg(IeAddr, 32'd3);
        writeReg(TxMarkAddr, 32'd1);
        readReg(IpAddr, data);
        compareValue("ip tx below mark", 32'd1, data);   // TX count 0 below 1
        compareValue("intr tx below mark", 32'd1, {31'h0, SPIIntr});
        writeReg(RxMarkAddr, 32'd2);
        sendBytes(3);
        readReg(IpAddr, data);
        compareValue("ip rx above mark", 32'd3, data);
        repeat (3) readRx("watermark drain");
        readReg(IpAddr, data);
        compareValue("ip rx drained", 32'd1, data);
        reportTest("watermark interrupts", mark);

        mark = errors;
        sendBytes(10);
        repeat (8) readRx("overflow kept");
        readReg(RxDataAddr, data);
        compareValue("overflow empty", 32'd1, {31'h0, data[RxEmptyBit]});
        sent.delete();                            // Last two bytes were lost
        reportTest("receive overflow", mark);

        $display("Tests passed %0d, failed %0d, assertion failures %0d",
                 testsPassed, testsFailed, DUT.engine.protoCheck.failCount);
        if (testsFailed == 0 && DUT.engine.protoCheck.failCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
rtl/spiPkg.sv
rtl/spiFifo.sv
rtl/spiRegs.sv
rtl/spiEngine.sv
rtl/spiApb.sv
verification/spiApb_checker.sv
verification/spiApbTb.sv

/* run.sh */
#!/bin/bash
# Build and run the SPI controller simulation with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module spiApbTb -o simv
./obj_dir/simv | tee sim.log
if grep -q "CHECKS FAILED" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"
